// File: dv/serial_loader_testdata.txt
# W addr len data..   R addr len expected..   C cmd expected_rsp   (hex)
# E count bytes..     the last byte is sent with a bad stop bit
W 0010 04 de ad be ef
R 0010 04 de ad be ef
W 0100 00
R 0011 02 ad be
# writes across the top of the 4 KiB space
W 0ffe 04 a1 b2 c3 d4
R 0ffe 02 a1 b2
R 0000 02 c3 d4
R 1ffe 04 a1 b2 c3 d4
# unknown commands, then normal frames
C 41 3f
C 00 3f
W 0200 03 01 02 03
R 0200 03 01 02 03
# framing errors in header, command and data
E 3 57 02 30
W 0230 02 5a a5
R 0230 02 5a a5
E 2 52 00
E 1 ff
E 6 57 00 40 04 aa bb
R 0040 01 aa
# back to back, zero-length reads send nothing
R 0300 00
W 0300 01 77
R 0000 00
R 0300 01 77
W 0002 03 10 20 30
R 0001 04 d4 10 20 30

// File: serial_loader.f
design/serial_loader_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/loader_ctrl.sv
design/byte_mem.sv
design/serial_loader.sv
dv/serial_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the serial loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f serial_loader.f --top-module serial_loader_tb

out=$(./obj_dir/Vserial_loader_tb || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

// File: dv/serial_loader_tb.sv
// serial loader testbench, driven from a data file
`timescale 1ns/1ps

module serial_loader_tb import serial_loader_pkg::*; ();

    logic clk = 1'b0;
    logic rst_n;
    logic rx;
    logic tx;

    byte_t send_q[$];  // bytes of the frame on rx
    byte_t exp_q[$];   // response bytes expected on tx

    serial_loader dut (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .tx    (tx)
    );

    always #4 clk = ~clk;  // 8 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // random idle gap, then start, 8 data bits lsb first, stop
    task automatic send_byte(input byte_t value, input bit bad_stop);
        int gap;
        gap = $urandom % 4;
        repeat (gap * CLKS_PER_BIT) @(negedge clk);
        rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = value[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx = bad_stop ? 1'b0 : 1'b1;  // a low stop bit is a framing error
        repeat (CLKS_PER_BIT) @(negedge clk);
        rx = 1'b1;
    endtask

    // returns in the middle of the stop bit
    task automatic receive_byte(input int timeout_clks, output byte_t value);
        int waited;
        waited = 0;
        while (tx !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > timeout_clks) begin
                abort_run("no start bit appeared on tx before the timeout");
            end
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);  // middle of start bit
        check_value("tx start bit", 8'h00, byte_t'(tx));
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            value[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_value("tx stop bit", 8'h01, byte_t'(tx));
    endtask

    task automatic expect_idle(input int clks);
        repeat (clks) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                abort_run("tx left idle when no response byte was expected");
            end
        end
    endtask

    // send the queued frame while collecting its response bytes
    task automatic run_frame(input bit bad_last);
        int limit;
        limit = (send_q.size() + exp_q.size() + 2) * 14 * CLKS_PER_BIT;
        fork
            begin
                for (int i = 0; i < send_q.size(); i++) begin
                    send_byte(send_q[i], bad_last && (i == send_q.size() - 1));
                end
            end
            begin
                byte_t got;
                for (int i = 0; i < exp_q.size(); i++) begin
                    receive_byte(limit, got);
                    check_value($sformatf("tx byte %0d", i), exp_q[i], got);
                end
            end
        join
        expect_idle(3 * CLKS_PER_BIT);  // nothing beyond the expected bytes
        send_q.delete();
        exp_q.delete();
    endtask

    task automatic read_hex(input int fd, output int value);
        int code;
        code = $fscanf(fd, " %h", value);
        if (code != 1) begin
            abort_run("malformed or truncated line in the data file");
        end
    endtask

    // header bytes of a W or R frame
    task automatic queue_header(input int fd, input byte_t cmd, output int len);
        int    v;
        addr_t addr;
        read_hex(fd, v);
        addr = addr_t'(v);
        read_hex(fd, len);
        send_q.push_back(cmd);
        send_q.push_back(addr[15:8]);
        send_q.push_back(addr[7:0]);
        send_q.push_back(byte_t'(len));
    endtask

    task automatic run_op(input int fd, input byte_t op);
        int len;
        int v;
        case (op)
            "W": begin
                queue_header(fd, CMD_WRITE, len);
                for (int i = 0; i < len; i++) begin
                    read_hex(fd, v);
                    send_q.push_back(byte_t'(v));
                end
                exp_q.push_back(RSP_ACK);
                run_frame(1'b0);
            end
            "R": begin
                queue_header(fd, CMD_READ, len);
                for (int i = 0; i < len; i++) begin
                    read_hex(fd, v);
                    exp_q.push_back(byte_t'(v));
                end
                run_frame(1'b0);
            end
            "C": begin
                read_hex(fd, v);
                send_q.push_back(byte_t'(v));  // raw command byte
                read_hex(fd, v);
                exp_q.push_back(byte_t'(v));
                run_frame(1'b0);
            end
            "E": begin
                read_hex(fd, len);
                for (int i = 0; i < len; i++) begin
                    read_hex(fd, v);
                    send_q.push_back(byte_t'(v));
                end
                exp_q.push_back(RSP_FRAME_ERR);
                run_frame(1'b1);  // last byte goes out with a bad stop bit
            end
            default: abort_run("unknown operation letter in the data file");
        endcase
    endtask

    initial begin
        int    fd;
        int    c;
        int    n_ops;
        bit    done;
        byte_t op;
        rx    = 1'b1;
        rst_n = 1'b0;
        void'($urandom(32'h31aa_6cd1));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        expect_idle(20 * CLKS_PER_BIT);  // line quiet after reset

        fd = $fopen("dv/serial_loader_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open dv/serial_loader_testdata.txt");
        end
        n_ops = 0;
        done  = 1'b0;
        while (!done) begin
            c = $fgetc(fd);
            if (c == -1) begin
                done = 1'b1;
            end else if (c == 35) begin  // '#' comment runs to end of line
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (c > 32) begin
                op = byte_t'(c);
                run_op(fd, op);
                n_ops++;
            end
        end
        $fclose(fd);

        if (n_ops == 0) begin
            abort_run("the data file held no operations");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: design/serial_loader.sv
// serial memory loader top level
`timescale 1ns/1ps

module serial_loader import serial_loader_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic tx
);

    byte_t      rx_data;
    logic       rx_stb;
    logic       rx_err;
    byte_t      tx_data;
    logic       tx_start;
    logic       tx_busy;
    mem_index_t mem_addr;
    logic       mem_we;
    byte_t      mem_wdata;
    byte_t      mem_rdata;

    uart_rx u_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .rx_data (rx_data),
        .rx_stb  (rx_stb),
        .rx_err  (rx_err)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    loader_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_data   (rx_data),
        .rx_stb    (rx_stb),
        .rx_err    (rx_err),
        .tx_busy   (tx_busy),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    byte_mem u_mem (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// File: design/byte_mem.sv
// 4 KiB byte memory, registered read
`timescale 1ns/1ps

module byte_mem import serial_loader_pkg::*; (
    input  logic       clk,
    input  logic       we,
    input  mem_index_t addr,
    input  byte_t      wdata,
    output byte_t      rdata
);

    byte_t mem [0:(1 << $bits(mem_index_t)) - 1];  // one entry per index

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // old data on a write cycle
    end

endmodule

// File: design/loader_ctrl.sv
// command frame controller
`timescale 1ns/1ps

module loader_ctrl import serial_loader_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  byte_t      rx_data,
    input  logic       rx_stb,
    input  logic       rx_err,
    input  logic       tx_busy,
    output logic       tx_start,
    output byte_t      tx_data,
    output mem_index_t mem_addr,
    output logic       mem_we,
    output byte_t      mem_wdata,
    input  byte_t      mem_rdata
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_ADDR_HI,
        S_ADDR_LO,
        S_LEN,
        S_WR_DATA,
        S_RD_FETCH,
        S_RD_SEND,
        S_RD_WAIT,
        S_RESPOND
    } loader_state_t;

    loader_state_t state;
    byte_t         cmd;
    addr_t         addr;
    byte_t         len_left;  // bytes still to move
    byte_t         rsp_code;

    assign mem_addr = mem_index_t'(addr);  // wraps at 0x0FFF
    assign tx_start = (state == S_RESPOND) || (state == S_RD_SEND);
    assign tx_data  = (state == S_RD_SEND) ? mem_rdata : rsp_code;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            mem_we <= 1'b0;
        end else begin
            mem_we <= 1'b0;
            if (mem_we) begin
                addr <= addr + 1'b1;  // step after each stored byte
            end
            case (state)
                S_IDLE: begin
                    if (rx_err) begin
                        rsp_code <= RSP_FRAME_ERR;
                        state    <= S_RESPOND;
                    end else if (rx_stb) begin
                        cmd <= rx_data;
                        if (rx_data == CMD_WRITE || rx_data == CMD_READ) begin
                            state <= S_ADDR_HI;
                        end else begin
                            rsp_code <= RSP_UNKNOWN;
                            state    <= S_RESPOND;
                        end
                    end
                end
                S_ADDR_HI, S_ADDR_LO, S_LEN: begin
                    if (rx_err) begin
                        rsp_code <= RSP_FRAME_ERR;
                        state    <= S_RESPOND;
                    end else if (rx_stb) begin
                        if (state == S_ADDR_HI) begin
                            addr  <= {rx_data, addr[7:0]};
                            state <= S_ADDR_LO;
                        end else if (state == S_ADDR_LO) begin
                            addr  <= {addr[15:8], rx_data};
                            state <= S_LEN;
                        end else begin
                            len_left <= rx_data;
                            rsp_code <= RSP_ACK;
                            if (cmd == CMD_WRITE) begin
                                state <= (rx_data == 8'd0) ? S_RESPOND : S_WR_DATA;
                            end else begin
                                state <= (rx_data == 8'd0) ? S_IDLE : S_RD_FETCH;
                            end
                        end
                    end
                end
                S_WR_DATA: begin
                    if (rx_err) begin
                        rsp_code <= RSP_FRAME_ERR;
                        state    <= S_RESPOND;
                    end else if (rx_stb) begin
                        mem_we    <= 1'b1;
                        mem_wdata <= rx_data;
                        len_left  <= len_left - 1'b1;
                    end else if (mem_we && len_left == 8'd0) begin
                        state <= S_RESPOND;  // ack once the last byte is stored
                    end
                end
                S_RD_FETCH: state <= S_RD_SEND;  // memory read latency
                S_RD_SEND: begin
                    addr     <= addr + 1'b1;
                    len_left <= len_left - 1'b1;
                    state    <= S_RD_WAIT;
                end
                S_RD_WAIT: begin
                    if (!tx_busy) begin
                        state <= (len_left == 8'd0) ? S_IDLE : S_RD_FETCH;
                    end
                end
                S_RESPOND: state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: design/uart_tx.sv
// uart transmitter
`timescale 1ns/1ps

module uart_tx import serial_loader_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t tx_data,
    input  logic  tx_start,
    output logic  tx,
    output logic  tx_busy
);

    logic [9:0]           shreg;    // stop, data, start
    logic [BIT_CNT_W-1:0] cnt;
    logic [3:0]           bit_idx;

    // all ones when idle, so the line rests high
    assign tx = shreg[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shreg   <= '1;
            tx_busy <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (tx_start && !tx_busy) begin
            shreg   <= {1'b1, tx_data, 1'b0};
            tx_busy <= 1'b1;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (tx_busy) begin
            if (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
                cnt   <= '0;
                shreg <= {1'b1, shreg[9:1]};  // fill with idle level
                if (bit_idx == 4'd9) begin
                    tx_busy <= 1'b0;          // end of stop bit
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/uart_rx.sv
// uart receiver, mid-bit sampling
`timescale 1ns/1ps

module uart_rx import serial_loader_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx,
    output byte_t rx_data,
    output logic  rx_stb,
    output logic  rx_err
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_last;    // previous synced level, for edge detect
    logic [BIT_CNT_W-1:0] cnt;
    logic [2:0]           bit_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            rx_stb  <= 1'b0;
            rx_err  <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
            rx_stb  <= 1'b0;
            rx_err  <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_last && !rx_sync) begin  // falling edge of start bit
                        state <= RX_START;
                        cnt   <= '0;
                    end
                end
                RX_START: begin
                    if (cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch rejection
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
                        cnt     <= '0;
                        rx_data <= {rx_sync, rx_data[7:1]};  // lsb first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
                        cnt    <= '0;
                        rx_stb <= rx_sync;
                        rx_err <= !rx_sync;  // stop bit sampled low
                        state  <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: design/serial_loader_pkg.sv
// serial loader shared types and constants

package serial_loader_pkg;

    // data widths
    typedef logic [7:0]  byte_t;       // serial and memory byte
    typedef logic [15:0] addr_t;       // host frame address
    typedef logic [11:0] mem_index_t;  // low 12 bits of the address

    // bit timing, short period for simulation
    localparam int CLKS_PER_BIT = 16;
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    // command bytes from the host
    localparam byte_t CMD_WRITE = 8'h57;  // 'W'
    localparam byte_t CMD_READ  = 8'h52;  // 'R'

    // response bytes to the host
    localparam byte_t RSP_ACK       = 8'h4B;  // 'K'
    localparam byte_t RSP_UNKNOWN   = 8'h3F;  // '?'
    localparam byte_t RSP_FRAME_ERR = 8'h21;  // '!'

endpackage
